// ==== hw/laser_link_consts.svh ====
`ifndef LASER_LINK_CONSTS_SVH
`define LASER_LINK_CONSTS_SVH

// handshake bytes
// offered by the transmitting station until the far end answers
`define LL_HS_SIGNAL    8'haa
`define LL_HS_REPLY     8'h10

// frame words, sent most significant byte first
// no two words share a first byte, the detector relies on it
`define LL_START_WORD   32'hc1c2c3c4
`define LL_DATA_WORD    32'hd1d2d3d4
`define LL_STOP_WORD    32'h51525354

// bytes written to the host per session, frame word included
`define LL_PKT_LEN      12'd32

// rx silence in cycles before a receive session is dropped
`define LL_TIMEOUT_LEN  12'd64

// cycles between the reply and the first data byte
`define LL_ALIGN_LEN    12'd12

// byte fifo depth, a power of two
`define LL_FIFO_DEPTH   64

`endif

// ==== hw/laser_link_pkg.sv ====
package laser_link_pkg;

    // one byte on the laser link
    typedef logic [7:0] byte_t;

    // frame word, four link bytes
    typedef logic [31:0] frame_word_t;

    // byte and cycle counters
    typedef logic [11:0] count_t;

    // producer side of a byte stream, ready travels the other way
    typedef struct packed {
        logic  valid;
        byte_t data;
    } byte_stream_t;

    // detector result, hit lasts one cycle
    typedef struct packed {
        logic        hit;
        frame_word_t word;
    } word_hit_t;

    // session FSM
    typedef enum logic [2:0] {
        idle,
        hs_tx_offer,
        tx_align,
        tx_send,
        hs_rx_reply,
        rx_load_word,
        rx_payload
    } link_state_t;

    // frame word matcher, one state per byte seen
    typedef enum logic [1:0] {
        match0,
        match1,
        match2,
        match3
    } detect_state_t;

endpackage

// ==== hw/byte_fifo.sv ====
`timescale 1ns/1ns

`include "laser_link_consts.svh"

module byte_fifo (
    input  logic                        clock,
    input  logic                        reset,
    input  laser_link_pkg::byte_stream_t wr_stream,
    output logic                        wr_ready,
    output laser_link_pkg::byte_stream_t rd_stream,
    input  logic                        rd_ready
);
    import laser_link_pkg::*;

    localparam int ptr_w = $clog2(`LL_FIFO_DEPTH);
    localparam logic [ptr_w:0] full_count = `LL_FIFO_DEPTH;

    byte_t            mem [`LL_FIFO_DEPTH];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [ptr_w:0]   count;
    logic             wr_fire;
    logic             rd_fire;

    assign wr_ready = (count != full_count);
    assign wr_fire  = wr_stream.valid && wr_ready;
    assign rd_fire  = rd_stream.valid && rd_ready;

    // head of queue straight from the array
    assign rd_stream.valid = (count != '0);
    assign rd_stream.data  = mem[rd_ptr];

    always_ff @(posedge clock) begin
        if (wr_fire) begin
            mem[wr_ptr] <= wr_stream.data;
        end
    end

    // pointers wrap on their own since the depth is a power of two
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_fire) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_fire) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_fire, rd_fire})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// ==== hw/frame_word_detector.sv ====
`timescale 1ns/1ns

`include "laser_link_consts.svh"

module frame_word_detector (
    input  logic                        clock,
    input  logic                        reset,
    input  laser_link_pkg::byte_stream_t rx,
    output laser_link_pkg::word_hit_t    word_hit
);
    import laser_link_pkg::*;

    localparam frame_word_t words [3] = '{`LL_START_WORD, `LL_DATA_WORD, `LL_STOP_WORD};

    detect_state_t state;
    logic [1:0]    sel;
    logic [1:0]    first_sel;
    logic          first_hit;
    byte_t         expect_byte;
    logic          byte_match;

    // which word, if any, starts with this byte
    always_comb begin
        first_hit = 1'b0;
        first_sel = 2'd0;
        for (int i = 0; i < 3; i++) begin
            if (rx.data == words[i][31:24]) begin
                first_hit = 1'b1;
                first_sel = 2'(i);
            end
        end
    end

    // next byte expected from the latched word
    always_comb begin
        case (state)
            match1:  expect_byte = words[sel][23:16];
            match2:  expect_byte = words[sel][15:8];
            match3:  expect_byte = words[sel][7:0];
            default: expect_byte = words[sel][31:24];
        endcase
    end

    assign byte_match = rx.valid && (rx.data == expect_byte);

    // fourth byte matched, reported in the same cycle
    assign word_hit.hit  = (state == match3) && byte_match;
    assign word_hit.word = words[sel];

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            state <= match0;
            sel   <= 2'd0;
        end else if (rx.valid) begin
            case (state)
                match0: begin
                    if (first_hit) begin
                        state <= match1;
                        sel   <= first_sel;
                    end
                end
                match1: state <= byte_match ? match2 : match0;
                match2: state <= byte_match ? match3 : match0;
                // hit or miss, start over
                default: state <= match0;
            endcase
        end
    end

endmodule

// ==== hw/link_controller.sv ====
`timescale 1ns/1ns

`include "laser_link_consts.svh"

module link_controller (
    input  logic                        clock,
    input  logic                        reset,
    input  laser_link_pkg::byte_stream_t rx,
    input  laser_link_pkg::word_hit_t    word_hit,
    input  laser_link_pkg::byte_stream_t q_in,
    output logic                        q_in_ready,
    output laser_link_pkg::byte_stream_t tx,
    input  logic                        tx_ready,
    output laser_link_pkg::byte_stream_t q_out,
    input  logic                        q_out_ready
);
    import laser_link_pkg::*;

    link_state_t state;
    frame_word_t saved_word;
    count_t      byte_cnt;
    count_t      cycle_cnt;
    logic        reply_pend;
    logic        hs_seen;
    logic        reply_seen;
    logic        start_tx;
    logic        start_rx;
    logic        rx_silent;
    logic        q_out_fire;
    byte_t       word_byte;

    assign hs_seen    = rx.valid && (rx.data == `LL_HS_SIGNAL);
    assign reply_seen = rx.valid && (rx.data == `LL_HS_REPLY);
    // a reply still owed on tx blocks a new transmit session
    assign start_tx   = q_in.valid && !reply_pend;
    assign start_rx   = hs_seen && !start_tx;
    assign rx_silent  = !rx.valid && (cycle_cnt == `LL_TIMEOUT_LEN - 12'd1);
    assign q_out_fire = q_out.valid && q_out_ready;

    // saved word, most significant byte first
    always_comb begin
        case (byte_cnt[1:0])
            2'd0:    word_byte = saved_word[31:24];
            2'd1:    word_byte = saved_word[23:16];
            2'd2:    word_byte = saved_word[15:8];
            default: word_byte = saved_word[7:0];
        endcase
    end

    always_comb begin
        tx         = '{valid: reply_pend, data: `LL_HS_REPLY};
        q_out      = '0;
        q_in_ready = 1'b0;
        case (state)
            hs_tx_offer: tx = '{valid: 1'b1, data: `LL_HS_SIGNAL};
            tx_send: begin
                tx         = q_in;
                q_in_ready = tx_ready;
            end
            rx_load_word: q_out = '{valid: 1'b1, data: word_byte};
            // payload passes straight through, dropped when the fifo is full
            rx_payload: q_out = rx;
            default: ;
        endcase
    end

    // while offering the handshake the flag means a reply was heard,
    // elsewhere it means a reply byte is owed on tx
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            reply_pend <= 1'b0;
        end else begin
            case (state)
                hs_tx_offer: reply_pend <= (reply_pend || reply_seen) && !tx_ready;
                idle:        reply_pend <= start_rx || (reply_pend && !tx_ready);
                hs_rx_reply: reply_pend <= hs_seen || (reply_pend && !tx_ready);
                default:     reply_pend <= reply_pend && !tx_ready;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (state == hs_rx_reply && word_hit.hit) begin
            saved_word <= word_hit.word;
        end
    end

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            state     <= idle;
            byte_cnt  <= '0;
            cycle_cnt <= '0;
        end else begin
            case (state)
                idle: begin
                    cycle_cnt <= '0;
                    if (start_tx) begin
                        state <= hs_tx_offer;
                    end else if (start_rx) begin
                        state <= hs_rx_reply;
                    end
                end
                // leave only once the offered byte is taken
                hs_tx_offer: begin
                    if ((reply_pend || reply_seen) && tx_ready) begin
                        state     <= tx_align;
                        cycle_cnt <= '0;
                    end
                end
                tx_align: begin
                    if (cycle_cnt == `LL_ALIGN_LEN - 12'd1) begin
                        state <= tx_send;
                    end else begin
                        cycle_cnt <= cycle_cnt + 12'd1;
                    end
                end
                tx_send: begin
                    if (!q_in.valid) begin
                        state <= idle;
                    end
                end
                hs_rx_reply: begin
                    cycle_cnt <= rx.valid ? '0 : cycle_cnt + 12'd1;
                    if (word_hit.hit) begin
                        state    <= rx_load_word;
                        byte_cnt <= '0;
                    end else if (rx_silent) begin
                        state <= idle;
                    end
                end
                rx_load_word: begin
                    cycle_cnt <= '0;
                    if (q_out_ready) begin
                        byte_cnt <= byte_cnt + 12'd1;
                        if (byte_cnt[1:0] == 2'd3) begin
                            state <= rx_payload;
                        end
                    end
                end
                rx_payload: begin
                    cycle_cnt <= rx.valid ? '0 : cycle_cnt + 12'd1;
                    if (q_out_fire) begin
                        byte_cnt <= byte_cnt + 12'd1;
                    end
                    if (q_out_fire && byte_cnt == `LL_PKT_LEN - 12'd1) begin
                        state <= idle;
                    end else if (rx_silent) begin
                        state <= idle;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

endmodule

// ==== hw/laser_link_top.sv ====
`timescale 1ns/1ns

module laser_link_top (
    input  logic                        clock,
    input  logic                        reset,
    input  laser_link_pkg::byte_stream_t host_in,
    output logic                        host_in_ready,
    output laser_link_pkg::byte_stream_t host_out,
    input  logic                        host_out_ready,
    input  laser_link_pkg::byte_stream_t rx,
    output laser_link_pkg::byte_stream_t tx,
    input  logic                        tx_ready
);
    import laser_link_pkg::*;

    byte_stream_t q_in;
    logic         q_in_ready;
    byte_stream_t q_out;
    logic         q_out_ready;
    word_hit_t    word_hit;

    // host bytes waiting for a transmit session
    byte_fifo u_in_fifo (
        .clock     (clock),
        .reset     (reset),
        .wr_stream (host_in),
        .wr_ready  (host_in_ready),
        .rd_stream (q_in),
        .rd_ready  (q_in_ready)
    );

    // received frame bytes for the host to drain
    byte_fifo u_out_fifo (
        .clock     (clock),
        .reset     (reset),
        .wr_stream (q_out),
        .wr_ready  (q_out_ready),
        .rd_stream (host_out),
        .rd_ready  (host_out_ready)
    );

    frame_word_detector u_detector (
        .clock    (clock),
        .reset    (reset),
        .rx       (rx),
        .word_hit (word_hit)
    );

    link_controller u_controller (
        .clock       (clock),
        .reset       (reset),
        .rx          (rx),
        .word_hit    (word_hit),
        .q_in        (q_in),
        .q_in_ready  (q_in_ready),
        .tx          (tx),
        .tx_ready    (tx_ready),
        .q_out       (q_out),
        .q_out_ready (q_out_ready)
    );

endmodule

// ==== sim/laser_link_chk.sv ====
`timescale 1ns/1ns

module laser_link_chk (
    input logic                         clock,
    input logic                         reset,
    input laser_link_pkg::byte_stream_t rx,
    input laser_link_pkg::byte_stream_t tx,
    input logic                         tx_ready,
    input laser_link_pkg::byte_stream_t host_out,
    input laser_link_pkg::word_hit_t    word_hit
);
    import laser_link_pkg::*;

    logic        word_seen;
    frame_word_t rx_hist;

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            word_seen <= 1'b0;
        end else if (word_hit.hit) begin
            word_seen <= 1'b1;
        end
    end

    // last valid rx bytes, oldest in the top byte
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            rx_hist <= '0;
        end else if (rx.valid) begin
            rx_hist <= {rx_hist[23:0], rx.data};
        end
    end

    // offered byte held until the transceiver takes it
    assert property (@(posedge clock) disable iff (reset)
        tx.valid && !tx_ready |=> tx.valid && $stable(tx.data))
        else $error("tx changed while tx_ready was low");

    // a hit ends four valid rx bytes that spell the reported word
    assert property (@(posedge clock) disable iff (reset)
        word_hit.hit |-> rx.valid && ({rx_hist[23:0], rx.data} == word_hit.word))
        else $error("word_hit.hit without the matching rx bytes");

    assert property (@(posedge clock) disable iff (reset)
        !host_out.valid || word_seen)
        else $error("host_out valid before any frame word");

endmodule

// ==== sim/laser_link_tb.sv ====
`timescale 1ns/1ns

`include "laser_link_consts.svh"

module laser_link_tb;
    import laser_link_pkg::*;

    typedef enum logic [2:0] {k_idle, k_tx, k_rx, k_miss, k_cut, k_hold} kind_t;

    typedef struct packed {
        kind_t       kind;
        count_t      count;
        frame_word_t word;
        logic [31:0] seed;
    } entry_t;

    logic         clock;
    logic         reset;
    byte_stream_t host_in;
    logic         host_in_ready;
    byte_stream_t host_out;
    logic         host_out_ready;
    byte_stream_t rx;
    byte_stream_t tx;
    logic         tx_ready;

    entry_t      tbl [7];
    byte_t       tx_log [$];
    byte_t       out_log [$];
    logic [31:0] pay_lfsr;
    logic [31:0] ready_lfsr;
    logic        hold_out;
    int          cycles;
    int          limit;

    laser_link_top u_laser_link_top (
        .clock          (clock),
        .reset          (reset),
        .host_in        (host_in),
        .host_in_ready  (host_in_ready),
        .host_out       (host_out),
        .host_out_ready (host_out_ready),
        .rx             (rx),
        .tx             (tx),
        .tx_ready       (tx_ready)
    );

    bind laser_link_top laser_link_chk u_chk (
        .clock          (clock),
        .reset          (reset),
        .rx             (rx),
        .tx             (tx),
        .tx_ready       (tx_ready),
        .host_out       (host_out),
        .word_hit       (word_hit)
    );

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic report_error(input string line);
        $display("%s", line);
        $display("Simulation FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_byte(input string name, input byte_t got, input byte_t exp);
        if (got !== exp) begin
            report_error($sformatf("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_word(input string name, input frame_word_t got, input frame_word_t exp);
        if (got !== exp) begin
            report_error($sformatf("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_count(input string name, input count_t got, input count_t exp);
        if (got !== exp) begin
            report_error($sformatf("Mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            report_error($sformatf("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp));
        end
    endtask

    task automatic gen_byte(output byte_t b);
        b = '0;
        for (int i = 0; i < 8; i++) begin
            pay_lfsr = lfsr_step(pay_lfsr);
            b = {b[6:0], pay_lfsr[0]};
        end
    endtask

    task automatic send_rx(input byte_t b);
        @(posedge clock);
        #10 rx = '{valid: 1'b1, data: b};
    endtask

    task automatic idle_rx(input int n);
        repeat (n) begin
            @(posedge clock);
            #10 rx = '0;
        end
    endtask

    task automatic pop_tx(output byte_t b);
        while (tx_log.size() == 0) @(negedge clock);
        b = tx_log.pop_front();
    endtask

    task automatic pop_out(output byte_t b);
        while (out_log.size() == 0) @(negedge clock);
        b = out_log.pop_front();
    endtask

    // accepted bytes are logged before the edge that moves them
    always @(negedge clock) begin
        if (!reset) begin
            if (tx.valid && tx_ready) tx_log.push_back(tx.data);
            if (host_out.valid && host_out_ready) out_log.push_back(host_out.data);
        end
    end

    // transceiver and host sinks
    always @(posedge clock) begin
        #10;
        ready_lfsr = lfsr_step(ready_lfsr);
        tx_ready = ready_lfsr[0];
        host_out_ready = !hold_out;
    end

    always @(posedge clock) begin
        cycles++;
        if (cycles > limit) begin
            $display("Timeout: the run did not finish within %0d cycles", limit);
            $display("Simulation FAILED");
            $fatal(1, "timeout");
        end
    end

    task automatic run_tx(input count_t n);
        byte_t exp_q [$];
        byte_t b;
        for (int i = 0; i < n; i++) begin
            gen_byte(b);
            // a leading handshake value would look like another offer
            if (i == 0 && b == `LL_HS_SIGNAL) b = 8'h55;
            exp_q.push_back(b);
            @(posedge clock);
            #10 host_in = '{valid: 1'b1, data: b};
            @(negedge clock);
            check_flag("host_in_ready", host_in_ready, 1'b1);
        end
        @(posedge clock);
        #10 host_in = '0;
        pop_tx(b);
        check_byte("tx.data offer", b, `LL_HS_SIGNAL);
        send_rx(`LL_HS_REPLY);
        idle_rx(1);
        pop_tx(b);
        while (b == `LL_HS_SIGNAL) pop_tx(b);
        check_byte("tx.data", b, exp_q[0]);
        for (int i = 1; i < n; i++) begin
            pop_tx(b);
            check_byte("tx.data", b, exp_q[i]);
        end
        idle_rx(20);
        check_count("tx bytes after session", count_t'(tx_log.size()), 12'd0);
    endtask

    task automatic run_rx(input entry_t e);
        byte_t       exp_q [$];
        byte_t       b;
        frame_word_t got_word;
        hold_out = (e.kind == k_hold);
        send_rx(`LL_HS_SIGNAL);
        idle_rx(1);
        pop_tx(b);
        check_byte("tx.data reply", b, `LL_HS_REPLY);
        send_rx(e.word[31:24]);
        send_rx(e.word[23:16]);
        send_rx(e.word[15:8]);
        if (e.kind == k_miss) begin
            send_rx(e.word[7:0] ^ 8'hff);
        end else begin
            send_rx(e.word[7:0]);
            idle_rx(6);
        end
        for (int i = 0; i < e.count; i++) begin
            gen_byte(b);
            if (e.kind == k_miss && (b == 8'hc1 || b == 8'hd1 || b == 8'h51 || b == 8'haa)) begin
                b = b ^ 8'h01;
            end
            exp_q.push_back(b);
            send_rx(b);
        end
        idle_rx(1);
        if (e.kind == k_miss) begin
            idle_rx(`LL_TIMEOUT_LEN + 20);
            check_count("host_out bytes on near miss", count_t'(out_log.size()), 12'd0);
            check_count("tx bytes on near miss", count_t'(tx_log.size()), 12'd0);
            return;
        end
        if (e.kind == k_hold) begin
            idle_rx(10);
            check_flag("host_out.valid while held", host_out.valid, 1'b1);
            check_byte("host_out.data while held", host_out.data, e.word[31:24]);
            hold_out = 1'b0;
        end
        for (int i = 0; i < 4; i++) begin
            pop_out(b);
            got_word = {got_word[23:0], b};
        end
        check_word("host_out word", got_word, e.word);
        foreach (exp_q[i]) begin
            pop_out(b);
            check_byte("host_out.data", b, exp_q[i]);
        end
        idle_rx(e.kind == k_cut ? `LL_TIMEOUT_LEN + 20 : 20);
        check_count("host_out extra bytes", count_t'(out_log.size()), 12'd0);
    endtask

    initial begin
        reset = 1'b1;
        host_in = '0;
        host_out_ready = 1'b0;
        rx = '0;
        tx_ready = 1'b0;
        hold_out = 1'b0;
        pay_lfsr = 32'hdd31bca6;
        ready_lfsr = 32'hdd31bca6;
        cycles = 0;
        tbl[0] = '{k_idle, 12'd20, 32'h0, 32'h0};
        tbl[1] = '{k_tx, 12'd10, 32'h0, 32'h0};
        tbl[2] = '{k_rx, `LL_PKT_LEN - 12'd4, `LL_START_WORD, 32'h1};
        tbl[3] = '{k_miss, 12'd12, `LL_DATA_WORD, 32'h2};
        tbl[4] = '{k_cut, 12'd6, `LL_DATA_WORD, 32'h3};
        tbl[5] = '{k_rx, `LL_PKT_LEN - 12'd4, `LL_STOP_WORD, 32'h4};
        tbl[6] = '{k_hold, `LL_PKT_LEN - 12'd4, `LL_START_WORD, 32'h5};
        limit = 2000;
        foreach (tbl[i]) limit += tbl[i].count * 200;
        repeat (10) @(posedge clock);
        #10 reset = 1'b0;
        foreach (tbl[i]) begin
            pay_lfsr = 32'hdd31bca6 ^ tbl[i].seed;
            case (tbl[i].kind)
                k_idle: begin
                    repeat (tbl[i].count) begin
                        @(negedge clock);
                        check_flag("tx.valid", tx.valid, 1'b0);
                        check_flag("host_out.valid", host_out.valid, 1'b0);
                    end
                end
                k_tx: run_tx(tbl[i].count);
                default: run_rx(tbl[i]);
            endcase
        end
        $display("Simulation PASSED");
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+hw
hw/laser_link_pkg.sv
hw/byte_fifo.sv
hw/frame_word_detector.sv
hw/link_controller.sv
hw/laser_link_top.sv
sim/laser_link_chk.sv
sim/laser_link_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run, then decide on the log
verilator --binary --timing -Wno-fatal --top-module laser_link_tb -f vlog.f \
    -o laser_link_sim > build.log 2>&1 \
    && ./obj_dir/laser_link_sim > sim.log 2>&1 \
    || echo "Simulation FAILED" >> sim.log
grep -q "Simulation FAILED" sim.log && { echo "run failed"; exit 1; } || { echo "run passed"; exit 0; }
